// ==== Bender.yml ====
package:
  name: preg_reclaim

sources:
  - target: rtl
    include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/commit_intake.sv
      - logic/commit_lane.sv
      - logic/arch_free_list.sv
      - logic/preg_reclaim_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_preg_reclaim.sv

// ==== all.f ====
+incdir+logic
logic/rename_pkg.sv
logic/commit_intake.sv
logic/commit_lane.sv
logic/arch_free_list.sv
logic/preg_reclaim_top.sv
verif/tb_clock_gen.sv
verif/tb_preg_reclaim.sv

// ==== logic/arch_free_list.sv ====
// Architectural free list
// Ring of free physical registers as seen with nothing speculative
// Head consumes one entry per alloc, tail appends freed pregs in lane order
// Whole ring exported for recovery, flush restores the reset contents
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module arch_free_list import rename_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       flush_i,
  input  lane_mask_t                alloc_valid_i,
  input  lane_mask_t                free_valid_i,
  input  preg_t [`COMMIT_WIDTH-1:0] free_preg_i,
  output preg_t [`PHY_REG_NUM-1:0]  arch_free_list_o,
  output preg_t                     head_o,
  output fl_cnt_t                   free_count_o
);

  typedef preg_t [`PHY_REG_NUM-1:0] ring_t;
  typedef logic [$clog2(`COMMIT_WIDTH+1)-1:0] req_cnt_t;

  ring_t    ring_q;
  ring_t    ring_d;
  preg_t    head_q;
  preg_t    head_d;
  preg_t    tail_q;
  preg_t    tail_d;
  preg_t    wr_idx;
  fl_cnt_t  count_q;
  fl_cnt_t  count_d;
  req_cnt_t alloc_cnt;
  req_cnt_t free_cnt;

  // Pregs above the architectural range start out free at index 0
  function automatic ring_t reset_ring();
    ring_t r;
    for (int i = 0; i < `PHY_REG_NUM; i++) begin
      r[i] = preg_t'(i + `ARCH_REG_NUM);
    end
    return r;
  endfunction

  // ==============================
  // Next ring state
  // ==============================

  always_comb begin
    alloc_cnt = '0;
    free_cnt  = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      alloc_cnt = alloc_cnt + req_cnt_t'(alloc_valid_i[i]);
      free_cnt  = free_cnt + req_cnt_t'(free_valid_i[i]);
    end

    // Freed pregs at successive tail slots, index wraps with preg_t width
    ring_d = ring_q;
    wr_idx = tail_q;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (free_valid_i[i]) begin
        ring_d[wr_idx] = free_preg_i[i];
        wr_idx         = wr_idx + preg_t'(1);
      end
    end
    tail_d = wr_idx;

    head_d  = head_q + preg_t'(alloc_cnt);
    // Occupancy grows by frees, shrinks by allocs
    count_d = count_q + fl_cnt_t'(free_cnt) - fl_cnt_t'(alloc_cnt);
  end

  // ==============================
  // State update
  // ==============================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ring_q  <= reset_ring();
      head_q  <= '0;
      tail_q  <= preg_t'(`RESET_FREE_NUM);
      count_q <= fl_cnt_t'(`RESET_FREE_NUM);
    end else if (flush_i) begin
      // Back to the reset picture
      ring_q  <= reset_ring();
      head_q  <= '0;
      tail_q  <= preg_t'(`RESET_FREE_NUM);
      count_q <= fl_cnt_t'(`RESET_FREE_NUM);
    end else begin
      // Never stalls
      ring_q  <= ring_d;
      head_q  <= head_d;
      tail_q  <= tail_d;
      count_q <= count_d;
    end
  end

  assign arch_free_list_o = ring_q;
  assign head_o           = head_q;
  assign free_count_o     = count_q;

  // Lanes never consume more than the ring holds
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q >= fl_cnt_t'(alloc_cnt)
  );

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= fl_cnt_t'(`PHY_REG_NUM)
  );

  // Pointers and occupancy stay consistent
  a_ptr_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    preg_t'(head_q + preg_t'(count_q)) == tail_q
  );

endmodule

`default_nettype wire

// ==== logic/commit_intake.sv ====
// Commit bundle intake
// Four-phase req/ack receiver for retire bundles
// Captures one bundle per handshake and fires its valid lanes for one cycle
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module commit_intake import rename_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       commit_req_i,
  input  lane_mask_t                bundle_valid_i,
  input  lane_mask_t                bundle_has_dest_i,
  input  areg_t [`COMMIT_WIDTH-1:0] bundle_areg_i,
  input  preg_t [`COMMIT_WIDTH-1:0] bundle_old_preg_i,
  output logic                      commit_ack_o,
  output lane_mask_t                lane_fire_o,
  output lane_mask_t                lane_has_dest_o,
  output areg_t [`COMMIT_WIDTH-1:0] lane_areg_o,
  output preg_t [`COMMIT_WIDTH-1:0] lane_old_preg_o
);

  intake_state_t             state_q;
  intake_state_t             state_d;
  logic                      accept;
  lane_mask_t                valid_q;
  lane_mask_t                has_dest_q;
  areg_t [`COMMIT_WIDTH-1:0] areg_q;
  preg_t [`COMMIT_WIDTH-1:0] old_preg_q;

  // ==============================
  // Handshake FSM
  // ==============================

  // New bundle only taken from IDLE, so ack is low before req can repeat
  assign accept = (state_q == IDLE) && commit_req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (commit_req_i) begin
          state_d = HOLD;
        end
      end
      // Fire cycle, source may already have dropped req
      HOLD: begin
        state_d = commit_req_i ? RELEASE : IDLE;
      end
      // Ack held until req is seen low
      RELEASE: begin
        if (!commit_req_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==============================
  // Bundle capture
  // ==============================

  // Payload only, qualified by state
  always_ff @(posedge clk) begin
    if (accept) begin
      valid_q    <= bundle_valid_i;
      has_dest_q <= bundle_has_dest_i;
      areg_q     <= bundle_areg_i;
      old_preg_q <= bundle_old_preg_i;
    end
  end

  // Ack high from the accepting edge until req falls
  assign commit_ack_o    = (state_q != IDLE);
  // Valid lanes pulse during the single HOLD cycle
  assign lane_fire_o     = valid_q & {`COMMIT_WIDTH{state_q == HOLD}};
  assign lane_has_dest_o = has_dest_q;
  assign lane_areg_o     = areg_q;
  assign lane_old_preg_o = old_preg_q;

  // Ack only rises after req was sampled high
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(commit_ack_o) |-> $past(commit_req_i)
  );

  // One fire per handshake, nothing more until ack has dropped
  a_single_fire: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|lane_fire_o) |=> (lane_fire_o == '0) until !commit_ack_o
  );

endmodule

`default_nettype wire

// ==== logic/commit_lane.sv ====
// Commit lane
// Qualifies one fired commit slot and registers its alloc/free request
// Keeps a wrapping count of the register writes this slot has retired
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module commit_lane import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         fire_i,
  input  wire         has_dest_i,
  input  areg_t       areg_i,
  input  preg_t       old_preg_i,
  output logic        alloc_valid_o,
  output logic        free_valid_o,
  output preg_t       free_preg_o,
  output retire_cnt_t retired_o
);

  logic        qualified;
  logic        req_q;
  preg_t       free_preg_q;
  retire_cnt_t retired_q;

  // ==============================
  // Qualification
  // ==============================

  // x0 never renames, so it neither takes nor returns a preg
  assign qualified = fire_i && has_dest_i && (areg_i != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      retired_q <= '0;
    end else begin
      req_q <= qualified;
      if (qualified) begin
        retired_q <= retired_q + retire_cnt_t'(1);
      end
    end
  end

  // Old mapping goes back to the free list
  always_ff @(posedge clk) begin
    if (qualified) begin
      free_preg_q <= old_preg_i;
    end
  end

  // One head entry consumed for every tail entry appended
  assign alloc_valid_o = req_q;
  assign free_valid_o  = req_q;
  assign free_preg_o   = free_preg_q;
  assign retired_o     = retired_q;

  // Requests pair up and follow a fire by exactly one cycle
  a_alloc_free_pair: assert property (
    @(posedge clk) disable iff (!rst_n)
    (alloc_valid_o || free_valid_o) |->
      (alloc_valid_o && free_valid_o && $past(fire_i && has_dest_i))
  );

endmodule

`default_nettype wire

// ==== logic/preg_reclaim_top.sv ====
// Physical register reclaim, commit side
// Intake, one commit lane per bundle slot and the architectural free list
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module preg_reclaim_top import rename_pkg::*; (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             flush_i,
  input  wire                             commit_req_i,
  input  lane_mask_t                      bundle_valid_i,
  input  lane_mask_t                      bundle_has_dest_i,
  input  areg_t [`COMMIT_WIDTH-1:0]       bundle_areg_i,
  input  preg_t [`COMMIT_WIDTH-1:0]       bundle_old_preg_i,
  output logic                            commit_ack_o,
  output preg_t [`PHY_REG_NUM-1:0]        arch_free_list_o,
  output preg_t                           head_o,
  output fl_cnt_t                         free_count_o,
  output retire_cnt_t [`COMMIT_WIDTH-1:0] retired_o
);

  // Intake to lanes
  lane_mask_t                lane_fire;
  lane_mask_t                lane_has_dest;
  areg_t [`COMMIT_WIDTH-1:0] lane_areg;
  preg_t [`COMMIT_WIDTH-1:0] lane_old_preg;

  // Lanes to free list
  lane_mask_t                alloc_valid;
  lane_mask_t                free_valid;
  preg_t [`COMMIT_WIDTH-1:0] free_preg;

  commit_intake i_intake (
    .clk               (clk),
    .rst_n             (rst_n),
    .commit_req_i      (commit_req_i),
    .bundle_valid_i    (bundle_valid_i),
    .bundle_has_dest_i (bundle_has_dest_i),
    .bundle_areg_i     (bundle_areg_i),
    .bundle_old_preg_i (bundle_old_preg_i),
    .commit_ack_o      (commit_ack_o),
    .lane_fire_o       (lane_fire),
    .lane_has_dest_o   (lane_has_dest),
    .lane_areg_o       (lane_areg),
    .lane_old_preg_o   (lane_old_preg)
  );

  // ==============================
  // Commit lanes
  // ==============================

  for (genvar g = 0; g < `COMMIT_WIDTH; g++) begin : g_lane
    commit_lane i_lane (
      .clk           (clk),
      .rst_n         (rst_n),
      .fire_i        (lane_fire[g]),
      .has_dest_i    (lane_has_dest[g]),
      .areg_i        (lane_areg[g]),
      .old_preg_i    (lane_old_preg[g]),
      .alloc_valid_o (alloc_valid[g]),
      .free_valid_o  (free_valid[g]),
      .free_preg_o   (free_preg[g]),
      .retired_o     (retired_o[g])
    );
  end

  arch_free_list i_free_list (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush_i),
    .alloc_valid_i    (alloc_valid),
    .free_valid_i     (free_valid),
    .free_preg_i      (free_preg),
    .arch_free_list_o (arch_free_list_o),
    .head_o           (head_o),
    .free_count_o     (free_count_o)
  );

endmodule

`default_nettype wire

// ==== logic/rename_defines.svh ====
// Rename back end sizing
// Lane count and register file sizes shared by the commit side
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Commit lanes per retire bundle
`define COMMIT_WIDTH 2

// Physical register file entries, power of two so ring indices wrap
`define PHY_REG_NUM 64

// Architectural registers, x0 is permanently mapped
`define ARCH_REG_NUM 32

// Free entries left once every architectural register holds a mapping
`define RESET_FREE_NUM (`PHY_REG_NUM - `ARCH_REG_NUM)

`endif

// ==== logic/rename_pkg.sv ====
// Rename package
// Register number, lane mask and counter types for the commit side
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  // Physical register number, also used as a ring index
  typedef logic [$clog2(`PHY_REG_NUM)-1:0] preg_t;

  // Architectural register number
  typedef logic [$clog2(`ARCH_REG_NUM)-1:0] areg_t;

  // One bit per commit lane
  typedef logic [`COMMIT_WIDTH-1:0] lane_mask_t;

  // Free list occupancy, 0 up to PHY_REG_NUM inclusive
  typedef logic [$clog2(`PHY_REG_NUM+1)-1:0] fl_cnt_t;

  // Per-lane retired write counter, wraps
  typedef logic [15:0] retire_cnt_t;

  // Four-phase intake handshake
  typedef enum logic [1:0] {
    IDLE,
    HOLD,
    RELEASE
  } intake_state_t;

endpackage

`default_nettype wire

// ==== verif/preg_reclaim_stimulus.txt ====
// cmd rep valid has_dest areg0 old0 areg1 old1 (cmd 0 reset 1 commit 2 flush f end)
// cmd 3 expect: cmd - count retired0 retired1 - - -
0 0 0  0 00 00 00 00
1 1 1  1 05 05 00 00 // lane 0 only
3 0 20 1 0  0  0  0
1 1 3  3 06 06 07 07 // both lanes
3 0 20 2 1  0  0  0
1 1 2  3 01 01 08 08 // lane 0 not valid
1 1 3  1 09 09 0a 0a // lane 1 without destination
1 1 3  3 00 00 0b 0b // lane 0 writes x0
1 1 0  3 0c 0c 0d 0d // empty bundle
1 1 3  2 0e 0e 00 10 // nothing qualifies
3 0 20 3 3  0  0  0
1 1e 3 3 11 11 12 12 // head and tail wrap
3 0 20 21 21 0 0  0
2 0 0  0 0  0  0  0
0 0 0  0 00 00 00 00
3 0 20 21 21 0 0  0
1 3 3  3 14 14 15 15
3 0 20 24 24 0 0  0
f 0 0  0 0  0  0  0

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock, active-low reset held for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_preg_reclaim.sv ====
// Testbench for the commit-side register reclaim block
// Replays commands from the stimulus file through four-phase handshakes
// Keeps its own model of the free-list ring and checks it after each step
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_preg_reclaim import rename_pkg::*; ;

  localparam int CLK_PERIOD = 8;
  localparam int REC_WORDS  = 8;
  localparam int MAX_LINES  = 64;
  localparam int ACK_WAIT   = 20;

  logic                            clk;
  logic                            rst_n;
  logic                            flush;
  logic                            commit_req;
  lane_mask_t                      bundle_valid;
  lane_mask_t                      bundle_has_dest;
  areg_t [`COMMIT_WIDTH-1:0]       bundle_areg;
  preg_t [`COMMIT_WIDTH-1:0]       bundle_old_preg;
  logic                            commit_ack;
  preg_t [`PHY_REG_NUM-1:0]        arch_free_list;
  preg_t                           head;
  fl_cnt_t                         free_count;
  retire_cnt_t [`COMMIT_WIDTH-1:0] retired;

  // Record columns cmd rep valid has_dest areg0 old0 areg1 old1
  logic [15:0] stim_mem [0:REC_WORDS*MAX_LINES-1];
  int          n_lines;
  bit          stim_ready;
  int          value_errors;
  int          proto_errors;
  int          checks;

  // Reference model with an array for the whole ring and a queue for live entries
  preg_t       model_ring [`PHY_REG_NUM];
  preg_t       model_head;
  preg_t       model_tail;
  preg_t       free_q [$];
  retire_cnt_t model_retired [`COMMIT_WIDTH];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  preg_reclaim_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (flush),
    .commit_req_i      (commit_req),
    .bundle_valid_i    (bundle_valid),
    .bundle_has_dest_i (bundle_has_dest),
    .bundle_areg_i     (bundle_areg),
    .bundle_old_preg_i (bundle_old_preg),
    .commit_ack_o      (commit_ack),
    .arch_free_list_o  (arch_free_list),
    .head_o            (head),
    .free_count_o      (free_count),
    .retired_o         (retired)
  );

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input fl_cnt_t got, input fl_cnt_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_retired(input string name, input retire_cnt_t got,
                               input retire_cnt_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // ==============================
  // Ring model
  // ==============================

  // Pregs above the architectural range free, starting at index 0
  task automatic reset_model();
    for (int i = 0; i < `PHY_REG_NUM; i++) begin
      model_ring[i] = preg_t'(i + `ARCH_REG_NUM);
    end
    model_head = '0;
    model_tail = preg_t'(`RESET_FREE_NUM);
    free_q.delete();
    for (int i = 0; i < `RESET_FREE_NUM; i++) begin
      free_q.push_back(model_ring[i]);
    end
  endtask

  // Qualified lane takes the head entry and gives back its old preg
  task automatic apply_commit(input lane_mask_t valid, input lane_mask_t has_dest,
                              input areg_t [`COMMIT_WIDTH-1:0] areg,
                              input preg_t [`COMMIT_WIDTH-1:0] old_preg);
    for (int l = 0; l < `COMMIT_WIDTH; l++) begin
      if (valid[l] && has_dest[l] && areg[l] != '0) begin
        void'(free_q.pop_front());
        model_head++;
        free_q.push_back(old_preg[l]);
        model_ring[model_tail] = old_preg[l];
        model_tail++;
        model_retired[l]++;
      end
    end
  endtask

  task automatic compare_model();
    for (int i = 0; i < `PHY_REG_NUM; i++) begin
      check_preg($sformatf("arch_free_list_o[%0d]", i), arch_free_list[i], model_ring[i]);
    end
    check_preg("head_o", head, model_head);
    check_count("free_count_o", free_count, fl_cnt_t'(free_q.size()));
    // Live entries in queue order starting at head
    foreach (free_q[i]) begin
      check_preg($sformatf("arch_free_list_o[head+%0d]", i),
                 arch_free_list[preg_t'(model_head + i)], free_q[i]);
    end
    for (int l = 0; l < `COMMIT_WIDTH; l++) begin
      check_retired($sformatf("retired_o[%0d]", l), retired[l], model_retired[l]);
    end
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < `RESET_FREE_NUM; i++) begin
      check_preg($sformatf("arch_free_list_o[%0d]", i), arch_free_list[i],
                 preg_t'(`ARCH_REG_NUM + i));
    end
    check_preg("head_o", head, '0);
    check_count("free_count_o", free_count, fl_cnt_t'(`RESET_FREE_NUM));
  endtask

  // ==============================
  // Stimulus
  // ==============================

  // Full four-phase exchange and then two edges for lanes and free list
  task automatic run_handshake(input lane_mask_t valid, input lane_mask_t has_dest,
                               input areg_t [`COMMIT_WIDTH-1:0] areg,
                               input preg_t [`COMMIT_WIDTH-1:0] old_preg);
    int waited;
    @(negedge clk);
    bundle_valid    = valid;
    bundle_has_dest = has_dest;
    bundle_areg     = areg;
    bundle_old_preg = old_preg;
    commit_req      = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!commit_ack && waited < ACK_WAIT);
    if (!commit_ack) begin
      proto_errors++;
      $display("Error: commit ack never arrived within %0d cycles", ACK_WAIT);
    end
    commit_req = 1'b0;
    waited = 0;
    while (commit_ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (commit_ack) begin
      proto_errors++;
      $display("Error: commit ack stayed high after req was dropped");
    end
    repeat (2) @(negedge clk);
  endtask

  // Budget of 200 cycles per stimulus line
  initial begin
    wait (stim_ready);
    #((n_lines + 1) * 200 * CLK_PERIOD);
    $display("Error: watchdog expired, the run did not complete in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [15:0]               cmd;
    int                        base;
    int                        rep;
    lane_mask_t                valid;
    lane_mask_t                has_dest;
    areg_t [`COMMIT_WIDTH-1:0] areg;
    preg_t [`COMMIT_WIDTH-1:0] old_preg;
    flush           = 1'b0;
    commit_req      = 1'b0;
    bundle_valid    = '0;
    bundle_has_dest = '0;
    bundle_areg     = '0;
    bundle_old_preg = '0;
    value_errors    = 0;
    proto_errors    = 0;
    checks          = 0;
    for (int l = 0; l < `COMMIT_WIDTH; l++) begin
      model_retired[l] = '0;
    end
    reset_model();

    $readmemh("verif/preg_reclaim_stimulus.txt", stim_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && !$isunknown(stim_mem[n_lines*REC_WORDS]) &&
           stim_mem[n_lines*REC_WORDS] != 16'hf) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      proto_errors++;
      $display("Error: stimulus file is missing or holds no commands");
    end
    stim_ready = 1'b1;

    @(posedge rst_n);
    @(negedge clk);
    for (int line = 0; line < n_lines; line++) begin
      base = line * REC_WORDS;
      cmd  = stim_mem[base];
      case (cmd)
        // Reset picture
        16'h0: begin
          check_reset_state();
          compare_model();
        end
        // Commit bundle with old pregs stepping by one on each repeat
        16'h1: begin
          rep      = int'(stim_mem[base+1]);
          valid    = lane_mask_t'(stim_mem[base+2]);
          has_dest = lane_mask_t'(stim_mem[base+3]);
          for (int r = 0; r < rep; r++) begin
            for (int l = 0; l < `COMMIT_WIDTH; l++) begin
              areg[l]     = areg_t'(stim_mem[base+4+2*l]);
              old_preg[l] = preg_t'(stim_mem[base+5+2*l] + r);
            end
            run_handshake(valid, has_dest, areg, old_preg);
            apply_commit(valid, has_dest, areg, old_preg);
            compare_model();
          end
        end
        16'h2: begin
          @(negedge clk);
          flush = 1'b1;
          @(negedge clk);
          flush = 1'b0;
          reset_model();
          compare_model();
        end
        // Expected count and retired values straight from the file
        16'h3: begin
          check_count("free_count_o", free_count, fl_cnt_t'(stim_mem[base+2]));
          for (int l = 0; l < `COMMIT_WIDTH; l++) begin
            check_retired($sformatf("retired_o[%0d]", l), retired[l],
                          retire_cnt_t'(stim_mem[base+3+l]));
          end
        end
        default: begin
          proto_errors++;
          $display("Error: unknown command %h on stimulus line %0d", cmd, line);
        end
      endcase
    end

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
